// ==== rtl/bus_map_pkg.sv ====
// bus map constants; the raw bus address carries a 0x4000 offset and each window decodes only 32 byte offsets
`default_nettype none

package bus_map_pkg;

    // byte-wide write-only register bus
    localparam int BUS_ADDR_W = 16;
    localparam int BUS_DATA_W = 8;

    // raw address minus this gives the internal bus address
    localparam logic [BUS_ADDR_W-1:0] BUS_ADDR_OFFSET = 16'h4000;

    // command sequencer window
    localparam logic [BUS_ADDR_W-1:0] CMD_BASEADDR = 16'h0000;
    localparam logic [BUS_ADDR_W-1:0] CMD_HIGHADDR = 16'h7FFF;

    // trigger (tlu) window
    localparam logic [BUS_ADDR_W-1:0] TLU_BASEADDR = 16'h8200;
    localparam logic [BUS_ADDR_W-1:0] TLU_HIGHADDR = 16'h82FF;

    // offset inside a window as seen by the execute stages
    localparam int LOCAL_ADDR_W = 5;

    // command registers
    localparam logic [LOCAL_ADDR_W-1:0] CMD_REG_START  = 5'd0;
    localparam logic [LOCAL_ADDR_W-1:0] CMD_REG_LENGTH = 5'd1;
    localparam logic [LOCAL_ADDR_W-1:0] CMD_REG_CTRL   = 5'd2;
    // first byte of command memory
    localparam logic [LOCAL_ADDR_W-1:0] CMD_MEM_OFFSET = 5'd16;

    // trigger veto mask register
    localparam logic [LOCAL_ADDR_W-1:0] TLU_REG_VETO = 5'd0;

endpackage

`default_nettype wire

// ==== rtl/readout_pkg.sv ====
// readout constants; blink dividers assume a 40 MHz CLK_40 and command length is capped at 128 bits
`default_nettype none

package readout_pkg;

    // command memory, one byte per word
    localparam int CMD_MEM_BYTES = 16;
    localparam int CMD_MEM_AW    = $clog2(CMD_MEM_BYTES);

    // bit counter and length register
    localparam int CMD_CNT_W = 8;
    localparam logic [CMD_CNT_W-1:0] CMD_MAX_BITS = 8'd128;

    // receiver channels feeding the status LEDs
    localparam int RX_CHANNELS = 4;

    // veto mask, bit 0 fifo full, bit 1 veto input
    localparam int VETO_W = 2;

    // full blink periods in CLK_40 cycles
    localparam int BLINK_SLOW_DIV = 40000000;
    localparam int BLINK_FAST_DIV = 13333333;
    localparam int BLINK_CNT_W    = $clog2(BLINK_SLOW_DIV);

    // toggle points, index 0 slow, index 1 fast
    localparam logic [BLINK_CNT_W-1:0] BLINK_LAST [2] = '{
        BLINK_CNT_W'(BLINK_SLOW_DIV / 2 - 1),
        BLINK_CNT_W'(BLINK_FAST_DIV / 2 - 1)
    };

    // trigger synchronizer depth
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== rtl/bus_decode.sv ====
// bus write decode; writes beyond the first 32 offsets of a window are dropped, and strobes lag the write by one cycle
`timescale 1ns/10ps
`default_nettype none

module bus_decode
(
    input  wire                                 CLK_40,
    input  wire                                 i_rst_n,
    input  wire [bus_map_pkg::BUS_ADDR_W-1:0]   i_add,
    input  wire [bus_map_pkg::BUS_DATA_W-1:0]   i_data,
    input  wire                                 i_wr_b,
    output logic                                o_cmd_wr,
    output logic                                o_tlu_wr,
    output logic [bus_map_pkg::LOCAL_ADDR_W-1:0] o_local_addr,
    output logic [bus_map_pkg::BUS_DATA_W-1:0]  o_wdata
);

    logic [bus_map_pkg::BUS_ADDR_W-1:0] bus_add;
    logic [bus_map_pkg::BUS_ADDR_W-1:0] cmd_off;
    logic [bus_map_pkg::BUS_ADDR_W-1:0] tlu_off;
    logic                               bus_wr;
    logic                               cmd_hit;
    logic                               tlu_hit;

    // strip the raw bus offset
    assign bus_add = i_add - bus_map_pkg::BUS_ADDR_OFFSET;
    assign bus_wr  = ~i_wr_b;

    // offsets wrap below base, so one compare covers both window edges
    assign cmd_off = bus_add - bus_map_pkg::CMD_BASEADDR;
    assign tlu_off = bus_add - bus_map_pkg::TLU_BASEADDR;

    // in window and inside the decoded local range
    assign cmd_hit = (cmd_off <= (bus_map_pkg::CMD_HIGHADDR - bus_map_pkg::CMD_BASEADDR))
                     && (cmd_off[bus_map_pkg::BUS_ADDR_W-1:bus_map_pkg::LOCAL_ADDR_W] == '0);
    assign tlu_hit = (tlu_off <= (bus_map_pkg::TLU_HIGHADDR - bus_map_pkg::TLU_BASEADDR))
                     && (tlu_off[bus_map_pkg::BUS_ADDR_W-1:bus_map_pkg::LOCAL_ADDR_W] == '0);

    // one-cycle strobes, high the cycle after the write
    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_cmd_wr <= 1'b0;
            o_tlu_wr <= 1'b0;
        end
        else
        begin
            o_cmd_wr <= bus_wr && cmd_hit;
            o_tlu_wr <= bus_wr && tlu_hit;
        end
    end

    // offset and data, valid alongside the strobes
    always_ff @(posedge CLK_40)
    begin
        if (bus_wr)
        begin
            o_local_addr <= cmd_hit ? cmd_off[bus_map_pkg::LOCAL_ADDR_W-1:0]
                                    : tlu_off[bus_map_pkg::LOCAL_ADDR_W-1:0];
            o_wdata      <= i_data;
        end
    end

    // windows are disjoint, so never both execute stages at once
    a_one_strobe: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        !(o_cmd_wr && o_tlu_wr))
        else $error("bus_decode: command and trigger strobes overlap");

endmodule

`default_nettype wire

// ==== rtl/cmd_sequencer.sv ====
// serial command sender; length is frozen during a send and a zero length never starts one
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer
(
    input  wire                                  CLK_40,
    input  wire                                  i_rst_n,
    input  wire                                  i_cmd_wr,
    input  wire [bus_map_pkg::LOCAL_ADDR_W-1:0]  i_local_addr,
    input  wire [bus_map_pkg::BUS_DATA_W-1:0]    i_wdata,
    input  wire                                  i_ext_start,
    output logic                                 o_cmd_data,
    output logic                                 o_cmd_ready,
    output logic                                 o_ext_enable
);

    logic [bus_map_pkg::BUS_DATA_W-1:0] cmd_mem [readout_pkg::CMD_MEM_BYTES];
    logic [readout_pkg::CMD_CNT_W-1:0]  cmd_length;
    logic [readout_pkg::CMD_CNT_W-1:0]  bit_cnt;
    logic                               mem_wr;
    logic                               start_wr;
    logic                               length_wr;
    logic                               ctrl_wr;
    logic                               start_req;
    logic                               start_go;
    logic                               next_bit;

    // register decode
    assign mem_wr    = i_cmd_wr && (i_local_addr >= bus_map_pkg::CMD_MEM_OFFSET);
    assign start_wr  = i_cmd_wr && (i_local_addr == bus_map_pkg::CMD_REG_START);
    // length frozen while a send runs or starts
    assign length_wr = i_cmd_wr && (i_local_addr == bus_map_pkg::CMD_REG_LENGTH)
                       && o_cmd_ready && !start_go;
    assign ctrl_wr   = i_cmd_wr && (i_local_addr == bus_map_pkg::CMD_REG_CTRL);

    // software start or accepted trigger starts only from idle
    assign start_req = start_wr || (i_ext_start && o_ext_enable);
    assign start_go  = start_req && o_cmd_ready && (cmd_length != '0);

    // byte index from upper counter bits and msb first inside a byte
    // counter sits at zero while idle so this is bit 0 at start
    assign next_bit = cmd_mem[bit_cnt[readout_pkg::CMD_MEM_AW+2:3]][~bit_cnt[2:0]];

    always_ff @(posedge CLK_40)
    begin
        if (mem_wr)
        begin
            cmd_mem[i_local_addr[readout_pkg::CMD_MEM_AW-1:0]] <= i_wdata;
        end
    end

    // length and control registers
    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cmd_length   <= '0;
            o_ext_enable <= 1'b0;
        end
        else
        begin
            if (length_wr)
            begin
                // clamp to memory size
                cmd_length <= (i_wdata > readout_pkg::CMD_MAX_BITS) ? readout_pkg::CMD_MAX_BITS
                                                                   : i_wdata;
            end
            if (ctrl_wr)
            begin
                o_ext_enable <= i_wdata[0];
            end
        end
    end

    // shift fsm keeps ready low for exactly length cycles
    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_cmd_ready <= 1'b1;
            o_cmd_data  <= 1'b0;
            bit_cnt     <= '0;
        end
        else if (start_go)
        begin
            o_cmd_ready <= 1'b0;
            o_cmd_data  <= next_bit;
            bit_cnt     <= {{(readout_pkg::CMD_CNT_W-1){1'b0}}, 1'b1};
        end
        else if (!o_cmd_ready)
        begin
            if (bit_cnt == cmd_length)
            begin
                // last bit done so the line returns to idle low
                o_cmd_ready <= 1'b1;
                o_cmd_data  <= 1'b0;
                bit_cnt     <= '0;
            end
            else
            begin
                o_cmd_data <= next_bit;
                bit_cnt    <= bit_cnt + 1'b1;
            end
        end
    end

    // counter tracks the frozen length across the whole send
    a_cnt_in_range: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        bit_cnt <= cmd_length)
        else $error("cmd_sequencer: bit counter beyond length");

    // idle line is quiet
    a_idle_low: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        o_cmd_ready |-> !o_cmd_data)
        else $error("cmd_sequencer: data high while ready");

endmodule

`default_nettype wire

// ==== rtl/trigger_gate.sv ====
// LEMO trigger gate; triggers during busy or veto are dropped, and busy holds until ready rises again
`timescale 1ns/10ps
`default_nettype none

module trigger_gate
(
    input  wire                                 CLK_40,
    input  wire                                 i_rst_n,
    input  wire                                 i_tlu_wr,
    input  wire [bus_map_pkg::LOCAL_ADDR_W-1:0] i_local_addr,
    input  wire [readout_pkg::VETO_W-1:0]       i_wdata,
    input  wire                                 i_lemo_trigger,
    input  wire                                 i_veto,
    input  wire                                 i_fifo_full,
    input  wire                                 i_cmd_ready,
    input  wire                                 i_ext_enable,
    output logic                                o_ext_start,
    output logic                                o_trigger_accepted,
    output logic                                o_tx_busy
);

    logic [readout_pkg::SYNC_STAGES-1:0] trig_sync;
    logic                                trig_prev;
    logic                                trig_rise;
    logic [readout_pkg::VETO_W-1:0]      veto_mask;
    logic                                vetoed;
    logic                                accept;
    logic                                busy;
    logic                                ready_prev;
    logic                                trig_ack;

    // async trigger in at lsb, edge taken after last stage
    assign trig_rise = trig_sync[readout_pkg::SYNC_STAGES-1] & ~trig_prev;

    // bit 0 fifo full, bit 1 veto input
    assign vetoed = |(veto_mask & {i_veto, i_fifo_full});
    assign accept = trig_rise & i_ext_enable & ~vetoed & ~busy;

    // rising edge of ready acknowledges the trigger
    assign trig_ack = i_cmd_ready & ~ready_prev;

    // same pulse drives the sequencer start
    assign o_ext_start = o_trigger_accepted;

    // busy line follows ready when triggering is off
    assign o_tx_busy = i_ext_enable ? busy : ~i_cmd_ready;

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            trig_sync <= '0;
            trig_prev <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[readout_pkg::SYNC_STAGES-2:0], i_lemo_trigger};
            trig_prev <= trig_sync[readout_pkg::SYNC_STAGES-1];
        end
    end

    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            veto_mask <= '0;
        end
        else if (i_tlu_wr && (i_local_addr == bus_map_pkg::TLU_REG_VETO))
        begin
            veto_mask <= i_wdata;
        end
    end

    // accept pulse, then busy from the next cycle
    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_trigger_accepted <= 1'b0;
            busy               <= 1'b0;
            ready_prev         <= 1'b1;
        end
        else
        begin
            o_trigger_accepted <= accept;
            ready_prev         <= i_cmd_ready;
            // new trigger wins over a late acknowledge
            if (o_trigger_accepted)
            begin
                busy <= 1'b1;
            end
            else if (trig_ack)
            begin
                busy <= 1'b0;
            end
        end
    end

    // sync edge spacing and busy set keep accepts apart
    a_no_accept_busy: assert property (@(posedge CLK_40) disable iff (!i_rst_n)
        o_trigger_accepted |-> !busy)
        else $error("trigger_gate: trigger accepted while busy");

endmodule

`default_nettype wire

// ==== rtl/status_led.sv ====
// status LEDs; blink rates assume a 40 MHz clock, and the outputs are combinational from the receiver levels
`timescale 1ns/10ps
`default_nettype none

module status_led
(
    input  wire                                 CLK_40,
    input  wire                                 i_rst_n,
    input  wire [readout_pkg::RX_CHANNELS-1:0]  i_rx_ready,
    input  wire [readout_pkg::RX_CHANNELS-1:0]  i_rx_dec_err,
    input  wire [readout_pkg::RX_CHANNELS-1:0]  i_rx_overflow,
    input  wire                                 i_fifo_full,
    output logic [readout_pkg::RX_CHANNELS:0]   o_led
);

    // index 0 slow blink, index 1 fast blink
    logic [readout_pkg::BLINK_CNT_W-1:0] blink_cnt [2];
    logic [1:0]                          blink_q;

    // toggle dividers, half period each
    always_ff @(posedge CLK_40 or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 2; i++)
            begin
                blink_cnt[i] <= '0;
            end
            blink_q <= '0;
        end
        else
        begin
            for (int i = 0; i < 2; i++)
            begin
                if (blink_cnt[i] == readout_pkg::BLINK_LAST[i])
                begin
                    blink_cnt[i] <= '0;
                    blink_q[i]   <= ~blink_q[i];
                end
                else
                begin
                    blink_cnt[i] <= blink_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb
    begin
        // per channel: off unless ready, fast on decode error, solid on overflow
        for (int n = 0; n < readout_pkg::RX_CHANNELS; n++)
        begin
            o_led[n] = i_rx_ready[n]
                       & ((i_rx_dec_err[n] ? blink_q[1] : blink_q[0]) | i_rx_overflow[n]);
        end
        // heartbeat, solid when fifo full
        o_led[readout_pkg::RX_CHANNELS] = blink_q[0] | i_fifo_full;
    end

endmodule

`default_nettype wire

// ==== rtl/readout_top.sv ====
// trigger and command top on one 40 MHz clock; receiver levels and FIFO full come from outside
`timescale 1ns/10ps
`default_nettype none

module readout_top
(
    input  wire                                CLK_40,
    input  wire                                i_rst_n,
    input  wire [bus_map_pkg::BUS_ADDR_W-1:0]  i_add,
    input  wire [bus_map_pkg::BUS_DATA_W-1:0]  i_data,
    input  wire                                i_wr_b,
    input  wire                                i_lemo_trigger,
    input  wire                                i_veto,
    input  wire                                i_fifo_full,
    input  wire [readout_pkg::RX_CHANNELS-1:0] i_rx_ready,
    input  wire [readout_pkg::RX_CHANNELS-1:0] i_rx_dec_err,
    input  wire [readout_pkg::RX_CHANNELS-1:0] i_rx_overflow,
    output wire                                o_cmd_data,
    output wire                                o_cmd_ready,
    output wire                                o_trigger_accepted,
    output wire                                o_tx_busy,
    output wire [readout_pkg::RX_CHANNELS:0]   o_led
);

    // decoded bus
    wire                                 cmd_wr;
    wire                                 tlu_wr;
    wire [bus_map_pkg::LOCAL_ADDR_W-1:0] local_addr;
    wire [bus_map_pkg::BUS_DATA_W-1:0]   wdata;

    // trigger to sequencer handshake levels
    wire ext_start;
    wire ext_enable;

    bus_decode u_bus_decode (
        .CLK_40       (CLK_40),
        .i_rst_n      (i_rst_n),
        .i_add        (i_add),
        .i_data       (i_data),
        .i_wr_b       (i_wr_b),
        .o_cmd_wr     (cmd_wr),
        .o_tlu_wr     (tlu_wr),
        .o_local_addr (local_addr),
        .o_wdata      (wdata)
    );

    cmd_sequencer u_cmd_sequencer (
        .CLK_40       (CLK_40),
        .i_rst_n      (i_rst_n),
        .i_cmd_wr     (cmd_wr),
        .i_local_addr (local_addr),
        .i_wdata      (wdata),
        .i_ext_start  (ext_start),
        .o_cmd_data   (o_cmd_data),
        .o_cmd_ready  (o_cmd_ready),
        .o_ext_enable (ext_enable)
    );

    // only the mask bits of the data byte reach the gate
    trigger_gate u_trigger_gate (
        .CLK_40             (CLK_40),
        .i_rst_n            (i_rst_n),
        .i_tlu_wr           (tlu_wr),
        .i_local_addr       (local_addr),
        .i_wdata            (wdata[readout_pkg::VETO_W-1:0]),
        .i_lemo_trigger     (i_lemo_trigger),
        .i_veto             (i_veto),
        .i_fifo_full        (i_fifo_full),
        .i_cmd_ready        (o_cmd_ready),
        .i_ext_enable       (ext_enable),
        .o_ext_start        (ext_start),
        .o_trigger_accepted (o_trigger_accepted),
        .o_tx_busy          (o_tx_busy)
    );

    status_led u_status_led (
        .CLK_40        (CLK_40),
        .i_rst_n       (i_rst_n),
        .i_rx_ready    (i_rx_ready),
        .i_rx_dec_err  (i_rx_dec_err),
        .i_rx_overflow (i_rx_overflow),
        .i_fifo_full   (i_fifo_full),
        .o_led         (o_led)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset; 100 ns period, reset held low for 8 rising edges and released 10 ns after
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
    output logic CLK_40,
    output logic o_rst_n
);

    // free running clock
    initial
    begin
        CLK_40 = 1'b0;
        forever
        begin
            #50 CLK_40 = ~CLK_40;
        end
    end

    // release in the drive slot after the 8th edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (8) @(posedge CLK_40);
        #10 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_readout_top.sv ====
// readout testbench; stops at the first error and LED blink periods far exceed the run
`timescale 1ns/10ps
`default_nettype none

module tb_readout_top;

    logic                                 CLK_40;
    logic                                 rst_n;
    logic [bus_map_pkg::BUS_ADDR_W-1:0]   bus_add;
    logic [bus_map_pkg::BUS_DATA_W-1:0]   bus_data;
    logic                                 bus_wr_b;
    logic                                 lemo_trigger;
    logic                                 veto;
    logic                                 fifo_full;
    logic [readout_pkg::RX_CHANNELS-1:0]  rx_ready;
    logic [readout_pkg::RX_CHANNELS-1:0]  rx_dec_err;
    logic [readout_pkg::RX_CHANNELS-1:0]  rx_overflow;
    wire                                  cmd_data;
    wire                                  cmd_ready;
    wire                                  trigger_accepted;
    wire                                  tx_busy;
    wire  [readout_pkg::RX_CHANNELS:0]    led;

    // lfsr state stepped once per random bit
    logic [31:0]  lfsr_state = 32'h564601bf;
    // byte 0 of command memory in the top byte
    logic [127:0] mem_image  = '0;
    // expected serial stream with bit k sent in the k-th low cycle
    logic [127:0] exp_stream = '0;
    int           exp_len      = 0;
    int           low_cycles   = 0;
    int           send_count   = 0;
    int           accept_count = 0;
    // 0 no busy check, 1 busy is inverse ready, 2 busy high during sends
    int           busy_mode    = 0;

    tb_clock_gen u_clock_gen (
        .CLK_40  (CLK_40),
        .o_rst_n (rst_n)
    );

    readout_top u_dut (
        .CLK_40             (CLK_40),
        .i_rst_n            (rst_n),
        .i_add              (bus_add),
        .i_data             (bus_data),
        .i_wr_b             (bus_wr_b),
        .i_lemo_trigger     (lemo_trigger),
        .i_veto             (veto),
        .i_fifo_full        (fifo_full),
        .i_rx_ready         (rx_ready),
        .i_rx_dec_err       (rx_dec_err),
        .i_rx_overflow      (rx_overflow),
        .o_cmd_data         (cmd_data),
        .o_cmd_ready        (cmd_ready),
        .o_trigger_accepted (trigger_accepted),
        .o_tx_busy          (tx_busy),
        .o_led              (led)
    );

    // galois step with taps for x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 32'hD0000001;
        end
        return next;
    endfunction

    // stream bit k comes from byte k/8 with msb first within the byte
    function automatic logic [127:0] expected_stream(input logic [127:0] image, input int length);
        logic [127:0] stream;
        int           byte_idx;
        int           bit_idx;
        stream = '0;
        for (int k = 0; k < length; k++)
        begin
            byte_idx  = k / 8;
            bit_idx   = 7 - (k % 8);
            stream[k] = image[(readout_pkg::CMD_MEM_BYTES - 1 - byte_idx) * 8 + bit_idx];
        end
        return stream;
    endfunction

    // raw bus addresses carry the bus offset
    function automatic logic [15:0] cmd_addr(input int offset);
        return bus_map_pkg::BUS_ADDR_OFFSET + bus_map_pkg::CMD_BASEADDR + 16'(offset);
    endfunction

    function automatic logic [15:0] tlu_addr(input int offset);
        return bus_map_pkg::BUS_ADDR_OFFSET + bus_map_pkg::TLU_BASEADDR + 16'(offset);
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("mismatch %s: got 0x%0h expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // inputs change 10 ns after the rising edge
    task automatic drive_slot();
        @(posedge CLK_40);
        #10;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] value);
        drive_slot();
        bus_add  = addr;
        bus_data = value;
        bus_wr_b = 1'b0;
        drive_slot();
        bus_wr_b = 1'b1;
    endtask

    task automatic wait_send(input int prev_count, input int limit);
        int cycles;
        cycles = 0;
        while (send_count == prev_count)
        begin
            if (cycles >= limit)
            begin
                report_failure("timeout waiting for a command send to finish");
            end
            @(posedge CLK_40);
            cycles++;
        end
    endtask

    task automatic wait_accept(input int prev_count, input int limit);
        int cycles;
        cycles = 0;
        while (accept_count == prev_count)
        begin
            if (cycles >= limit)
            begin
                report_failure("timeout waiting for an accepted trigger");
            end
            @(posedge CLK_40);
            cycles++;
        end
    endtask

    // one rising edge held long enough for the synchronizer
    task automatic trigger_edge();
        drive_slot();
        lemo_trigger = 1'b1;
        repeat (4) drive_slot();
        lemo_trigger = 1'b0;
        repeat (4) drive_slot();
    endtask

    // random bytes into memory and then the length register
    task automatic load_command(input int length);
        logic [31:0] r;
        for (int i = 0; i < readout_pkg::CMD_MEM_BYTES; i++)
        begin
            random_bits(8, r);
            mem_image[(readout_pkg::CMD_MEM_BYTES - 1 - i) * 8 +: 8] = r[7:0];
            bus_write(cmd_addr(int'(bus_map_pkg::CMD_MEM_OFFSET) + i), r[7:0]);
        end
        bus_write(cmd_addr(int'(bus_map_pkg::CMD_REG_LENGTH)), 8'(length));
        exp_stream = expected_stream(mem_image, length);
        exp_len    = length;
    endtask

    task automatic software_send();
        logic [31:0] r;
        int          prev;
        random_bits(7, r);
        load_command(int'(r[6:0]) + 1);
        prev = send_count;
        bus_write(cmd_addr(int'(bus_map_pkg::CMD_REG_START)), 8'h00);
        wait_send(prev, 200);
    endtask

    // masked source must block and a cleared mask lets the same trigger through
    task automatic veto_check(input logic [7:0] mask);
        int prev_acc;
        int prev_send;
        prev_acc  = accept_count;
        prev_send = send_count;
        bus_write(tlu_addr(int'(bus_map_pkg::TLU_REG_VETO)), mask);
        trigger_edge();
        repeat (20) drive_slot();
        check_value("o_trigger_accepted pulses", accept_count, prev_acc);
        bus_write(tlu_addr(int'(bus_map_pkg::TLU_REG_VETO)), 8'h00);
        trigger_edge();
        wait_accept(prev_acc, 20);
        wait_send(prev_send, 300);
    endtask

    task automatic hold_led(input int index, input int value, input int cycles);
        repeat (cycles)
        begin
            drive_slot();
            check_value($sformatf("o_led[%0d]", index), 32'(led[index]), value);
        end
    endtask

    // sampled mid cycle to count sends and accepted pulses
    always @(negedge CLK_40)
    begin
        if (rst_n)
        begin
            if (trigger_accepted)
            begin
                accept_count++;
            end
            if (!cmd_ready)
            begin
                if (low_cycles >= readout_pkg::CMD_MAX_BITS)
                begin
                    report_failure("o_cmd_ready stayed low longer than the largest length");
                end
                check_value($sformatf("o_cmd_data bit %0d", low_cycles), 32'(cmd_data),
                            32'(exp_stream[low_cycles]));
                if (busy_mode == 2)
                begin
                    check_value("o_tx_busy", 32'(tx_busy), 1);
                end
                low_cycles++;
            end
            else
            begin
                check_value("o_cmd_data", 32'(cmd_data), 0);
                // ready just rose so one send is complete
                if (low_cycles != 0)
                begin
                    check_value("o_cmd_ready low cycles", low_cycles, exp_len);
                    send_count++;
                    low_cycles = 0;
                end
            end
            if (busy_mode == 1)
            begin
                check_value("o_tx_busy", 32'(tx_busy), 32'(!cmd_ready));
            end
        end
    end

    initial
    begin
        int          cycles;
        int          prev_acc;
        int          prev_send;
        logic [31:0] r;

        bus_add      = '0;
        bus_data     = '0;
        bus_wr_b     = 1'b1;
        lemo_trigger = 1'b0;
        veto         = 1'b0;
        fifo_full    = 1'b0;
        rx_ready     = '0;
        rx_dec_err   = '0;
        rx_overflow  = '0;

        cycles = 0;
        while (!rst_n)
        begin
            if (cycles >= 20)
            begin
                report_failure("reset was never released");
            end
            @(posedge CLK_40);
            cycles++;
        end

        // reset values
        drive_slot();
        check_value("o_cmd_ready", 32'(cmd_ready), 1);
        check_value("o_cmd_data", 32'(cmd_data), 0);
        check_value("o_trigger_accepted", 32'(trigger_accepted), 0);
        check_value("o_tx_busy", 32'(tx_busy), 0);
        check_value("o_led", 32'(led), 0);

        // software sends with external start off
        busy_mode = 1;
        repeat (4) software_send();

        // trigger send where the second edge lands inside the send
        bus_write(cmd_addr(int'(bus_map_pkg::CMD_REG_CTRL)), 8'h01);
        busy_mode = 2;
        random_bits(6, r);
        load_command(33 + int'(r[5:0]));
        prev_acc  = accept_count;
        prev_send = send_count;
        trigger_edge();
        wait_accept(prev_acc, 20);
        trigger_edge();
        wait_send(prev_send, 300);
        repeat (30) drive_slot();
        check_value("o_trigger_accepted pulses", accept_count, prev_acc + 1);
        check_value("command sends", send_count, prev_send + 1);
        check_value("o_tx_busy", 32'(tx_busy), 0);

        // veto by fifo full and then by the veto input
        drive_slot();
        fifo_full = 1'b1;
        veto_check(8'h01);
        drive_slot();
        fifo_full = 1'b0;
        veto      = 1'b1;
        veto_check(8'h02);
        drive_slot();
        veto = 1'b0;

        // receiver LEDs where overflow only shows once ready
        for (int n = 0; n < readout_pkg::RX_CHANNELS; n++)
        begin
            drive_slot();
            rx_ready       = '0;
            rx_overflow    = '0;
            rx_overflow[n] = 1'b1;
            hold_led(n, 0, 50);
            rx_ready[n] = 1'b1;
            hold_led(n, 1, 50);
        end
        fifo_full = 1'b1;
        hold_led(readout_pkg::RX_CHANNELS, 1, 50);
        fifo_full = 1'b0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/bus_map_pkg.sv
rtl/readout_pkg.sv
rtl/bus_decode.sv
rtl/cmd_sequencer.sv
rtl/trigger_gate.sv
rtl/status_led.sv
rtl/readout_top.sv
test/tb_clock_gen.sv
test/tb_readout_top.sv

// ==== Makefile ====
# Verilator build and run for the readout testbench
TOP = tb_readout_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f

# pass only when the pass line shows up in the output
run: build
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing --top-module readout_top -f sim.f

clean:
	rm -rf obj_dir
